//--- common/mont_pkg.sv
package mont_pkg;

    // operand width of the multiplier
    localparam int DEFAULT_N = 512;

    // slice handled per cycle by the serial adder
    localparam int DEFAULT_LIMB_W = 64;

endpackage

//--- common/mont_ctrl_pkg.sv
package mont_ctrl_pkg;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SCAN,
        ST_ADD_B_WAIT,
        ST_ODD_CHECK,
        ST_ADD_M_WAIT,
        ST_SHIFT,
        ST_SUB_WAIT,
        ST_SUB_CHECK,
        ST_EXT_WAIT,
        ST_DONE
    } state_t;

    // which pair of operands feeds the adder
    typedef enum logic [1:0] {
        SEL_C_B = 2'd0,
        SEL_C_M = 2'd1,
        SEL_EXT = 2'd2
    } opnd_sel_t;

endpackage

//--- rtl/mp_adder.sv
module mp_adder import mont_pkg::*; #(
    parameter int W      = DEFAULT_N + DEFAULT_LIMB_W,
    parameter int LIMB_W = DEFAULT_LIMB_W
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         add_start,
    input  logic         add_sub,
    input  logic [W-1:0] op_a,
    input  logic [W-1:0] op_b,
    output logic [W-1:0] sum,
    output logic         borrow,
    output logic         add_done
);
    localparam int LIMBS = W / LIMB_W;
    localparam int CNT_W = $clog2(LIMBS + 1);

    logic [CNT_W-1:0] limbs_left;
    logic             busy;
    logic [W-1:0]     a_q;
    logic [W-1:0]     b_q;
    logic             carry_q;
    logic             sub_q;
    logic [W-1:0]     a_in;
    logic [W-1:0]     b_in;
    logic             carry_in;
    logic [LIMB_W:0]  limb_sum;

    assign busy = (limbs_left != '0);

    // low limb is taken straight from the ports in the start cycle
    always_comb begin
        if (add_start) begin
            a_in     = op_a;
            b_in     = add_sub ? ~op_b : op_b;
            carry_in = add_sub;
        end else begin
            a_in     = a_q;
            b_in     = b_q;
            carry_in = carry_q;
        end
        limb_sum = {1'b0, a_in[LIMB_W-1:0]} + {1'b0, b_in[LIMB_W-1:0]}
                 + (LIMB_W + 1)'(carry_in);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            limbs_left <= '0;
            add_done   <= 1'b0;
        end else begin
            add_done <= 1'b0;
            if (add_start) begin
                limbs_left <= CNT_W'(LIMBS - 1);
                add_done   <= (LIMBS == 1);
            end else if (busy) begin
                limbs_left <= limbs_left - 1'b1;
                add_done   <= (limbs_left == CNT_W'(1));
            end
        end
    end

    // operands shift down, finished limbs enter the sum from the top
    always_ff @(posedge clk) begin
        if (add_start || busy) begin
            a_q     <= a_in >> LIMB_W;
            b_q     <= b_in >> LIMB_W;
            carry_q <= limb_sum[LIMB_W];
            sum     <= {limb_sum[LIMB_W-1:0], sum[W-1:LIMB_W]};
        end
        if (add_start) begin
            sub_q <= add_sub;
        end
    end

    // no carry out of a subtraction means the result went negative
    assign borrow = sub_q & ~carry_q;

    start_while_idle: assert property (@(posedge clk) disable iff (rst)
        add_start |-> !busy);

endmodule

//--- mont_core/mont_ctrl.sv
module mont_ctrl import mont_pkg::*, mont_ctrl_pkg::*; #(
    parameter int N = DEFAULT_N
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      mode_add,
    input  logic      add_sub,
    input  logic      a_lsb,
    input  logic      c_lsb,
    input  logic      add_done,
    input  logic      borrow,
    output logic      a_load,
    output logic      a_shift,
    output logic      c_clear,
    output logic      c_load,
    output logic      c_shift,
    output logic      res_load_c,
    output logic      res_load_sum,
    output logic      add_start,
    output logic      add_sub_o,
    output opnd_sel_t opnd_sel,
    output logic      done
);
    localparam int CNT_W = $clog2(N + 1);

    state_t           state;
    state_t           state_nxt;
    logic [CNT_W-1:0] bit_cnt;
    logic             cnt_load;
    logic             cnt_dec;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (cnt_load) begin
                bit_cnt <= CNT_W'(N);
            end else if (cnt_dec) begin
                bit_cnt <= bit_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt    = state;
        a_load       = 1'b0;
        a_shift      = 1'b0;
        c_clear      = 1'b0;
        c_load       = 1'b0;
        c_shift      = 1'b0;
        res_load_c   = 1'b0;
        res_load_sum = 1'b0;
        add_start    = 1'b0;
        add_sub_o    = 1'b0;
        opnd_sel     = SEL_C_B;
        cnt_load     = 1'b0;
        cnt_dec      = 1'b0;
        done         = 1'b0;

        case (state)
            ST_IDLE: begin
                if (start && mode_add) begin
                    add_start = 1'b1;
                    add_sub_o = add_sub;
                    opnd_sel  = SEL_EXT;
                    state_nxt = ST_EXT_WAIT;
                end else if (start) begin
                    a_load    = 1'b1;
                    c_clear   = 1'b1;
                    cnt_load  = 1'b1;
                    state_nxt = ST_SCAN;
                end
            end
            ST_SCAN: begin
                if (bit_cnt == '0) begin
                    // final reduction once all bits are done
                    add_start = 1'b1;
                    add_sub_o = 1'b1;
                    opnd_sel  = SEL_C_M;
                    state_nxt = ST_SUB_WAIT;
                end else if (a_lsb) begin
                    add_start = 1'b1;
                    state_nxt = ST_ADD_B_WAIT;
                end else begin
                    state_nxt = ST_ODD_CHECK;
                end
            end
            ST_ADD_B_WAIT: begin
                if (add_done) begin
                    c_load    = 1'b1;
                    state_nxt = ST_ODD_CHECK;
                end
            end
            ST_ODD_CHECK: begin
                if (c_lsb) begin
                    add_start = 1'b1;
                    opnd_sel  = SEL_C_M;
                    state_nxt = ST_ADD_M_WAIT;
                end else begin
                    state_nxt = ST_SHIFT;
                end
            end
            ST_ADD_M_WAIT: begin
                if (add_done) begin
                    c_load    = 1'b1;
                    state_nxt = ST_SHIFT;
                end
            end
            ST_SHIFT: begin
                a_shift   = 1'b1;
                c_shift   = 1'b1;
                cnt_dec   = 1'b1;
                state_nxt = ST_SCAN;
            end
            ST_SUB_WAIT: begin
                if (add_done) begin
                    state_nxt = ST_SUB_CHECK;
                end
            end
            ST_SUB_CHECK: begin
                if (borrow) begin
                    res_load_c = 1'b1;
                    state_nxt  = ST_DONE;
                end else begin
                    // keep the difference and let the scan state issue the next pass
                    c_load    = 1'b1;
                    state_nxt = ST_SCAN;
                end
            end
            ST_EXT_WAIT: begin
                if (add_done) begin
                    res_load_sum = 1'b1;
                    state_nxt    = ST_DONE;
                end
            end
            ST_DONE: begin
                done      = 1'b1;
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    adder_done_when_waiting: assert property (@(posedge clk) disable iff (rst)
        add_done |-> (state inside {ST_ADD_B_WAIT, ST_ADD_M_WAIT,
                                    ST_SUB_WAIT, ST_EXT_WAIT}));

endmodule

//--- mont_core/mont_datapath.sv
module mont_datapath import mont_pkg::*, mont_ctrl_pkg::*; #(
    parameter int N = DEFAULT_N,
    parameter int W = DEFAULT_N + DEFAULT_LIMB_W
) (
    input  logic         clk,
    input  logic         rst,
    input  logic [N-1:0] in_a,
    input  logic [N-1:0] in_b,
    input  logic [N-1:0] in_m,
    input  logic [N:0]   add_a,
    input  logic [N:0]   add_b,
    input  logic         a_load,
    input  logic         a_shift,
    input  logic         c_clear,
    input  logic         c_load,
    input  logic         c_shift,
    input  logic         res_load_c,
    input  logic         res_load_sum,
    input  opnd_sel_t    opnd_sel,
    input  logic [W-1:0] sum,
    output logic         a_lsb,
    output logic         c_lsb,
    output logic [W-1:0] op_a,
    output logic [W-1:0] op_b,
    output logic [N:0]   result
);
    logic [N-1:0] a_q;
    logic [W-1:0] c_q;
    logic [W-1:0] b_ext;
    logic [W-1:0] m_ext;
    logic [W-1:0] xa_ext;
    logic [W-1:0] xb_ext;

    assign b_ext  = W'(in_b);
    assign m_ext  = W'(in_m);
    assign xa_ext = W'(add_a);
    assign xb_ext = W'(add_b);

    // multiplier bits leave from the bottom
    always_ff @(posedge clk) begin
        if (a_load) begin
            a_q <= in_a;
        end else if (a_shift) begin
            a_q <= a_q >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || c_clear) begin
            c_q <= '0;
        end else if (c_load) begin
            c_q <= sum;
        end else if (c_shift) begin
            c_q <= c_q >> 1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (res_load_c) begin
            result <= c_q[N:0];
        end else if (res_load_sum) begin
            result <= sum[N:0];
        end
    end

    always_comb begin
        case (opnd_sel)
            SEL_C_M: begin
                op_a = c_q;
                op_b = m_ext;
            end
            SEL_EXT: begin
                op_a = xa_ext;
                op_b = xb_ext;
            end
            default: begin
                op_a = c_q;
                op_b = b_ext;
            end
        endcase
    end

    assign a_lsb = a_q[0];
    assign c_lsb = c_q[0];

    a_load_shift_excl: assert property (@(posedge clk) disable iff (rst)
        !(a_load && a_shift));

endmodule

//--- rtl/mont_top.sv
module mont_top import mont_pkg::*, mont_ctrl_pkg::*; #(
    parameter int N      = DEFAULT_N,
    parameter int LIMB_W = DEFAULT_LIMB_W
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         mode_add,
    input  logic         add_sub,
    input  logic [N-1:0] in_a,
    input  logic [N-1:0] in_b,
    input  logic [N-1:0] in_m,
    input  logic [N:0]   add_a,
    input  logic [N:0]   add_b,
    output logic [N:0]   result,
    output logic         done
);
    // one spare limb of headroom above the operands
    localparam int W = N + LIMB_W;

    logic         a_load;
    logic         a_shift;
    logic         c_clear;
    logic         c_load;
    logic         c_shift;
    logic         res_load_c;
    logic         res_load_sum;
    opnd_sel_t    opnd_sel;
    logic         a_lsb;
    logic         c_lsb;
    logic         add_start;
    logic         adder_sub;
    logic         add_done;
    logic         borrow;
    logic [W-1:0] op_a;
    logic [W-1:0] op_b;
    logic [W-1:0] sum;

    mont_ctrl #(
        .N (N)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .mode_add     (mode_add),
        .add_sub      (add_sub),
        .a_lsb        (a_lsb),
        .c_lsb        (c_lsb),
        .add_done     (add_done),
        .borrow       (borrow),
        .a_load       (a_load),
        .a_shift      (a_shift),
        .c_clear      (c_clear),
        .c_load       (c_load),
        .c_shift      (c_shift),
        .res_load_c   (res_load_c),
        .res_load_sum (res_load_sum),
        .add_start    (add_start),
        .add_sub_o    (adder_sub),
        .opnd_sel     (opnd_sel),
        .done         (done)
    );

    mont_datapath #(
        .N (N),
        .W (W)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_m         (in_m),
        .add_a        (add_a),
        .add_b        (add_b),
        .a_load       (a_load),
        .a_shift      (a_shift),
        .c_clear      (c_clear),
        .c_load       (c_load),
        .c_shift      (c_shift),
        .res_load_c   (res_load_c),
        .res_load_sum (res_load_sum),
        .opnd_sel     (opnd_sel),
        .sum          (sum),
        .a_lsb        (a_lsb),
        .c_lsb        (c_lsb),
        .op_a         (op_a),
        .op_b         (op_b),
        .result       (result)
    );

    mp_adder #(
        .W      (W),
        .LIMB_W (LIMB_W)
    ) u_adder (
        .clk       (clk),
        .rst       (rst),
        .add_start (add_start),
        .add_sub   (adder_sub),
        .op_a      (op_a),
        .op_b      (op_b),
        .sum       (sum),
        .borrow    (borrow),
        .add_done  (add_done)
    );

endmodule

//--- dv/mont_ref.svh
`ifndef MONT_REF_SVH
`define MONT_REF_SVH

// a * b * 2^-64 mod m, one multiplier bit per step, lowest first
function automatic logic [64:0] mont_mul_ref(input logic [63:0] a,
                                             input logic [63:0] b,
                                             input logic [63:0] m);
    logic [127:0] c;
    int           i;
    c = '0;
    for (i = 0; i < 64; i++) begin
        if (a[i]) begin
            c = c + 128'(b);
        end
        if (c[0]) begin
            c = c + 128'(m);
        end
        c = c >> 1;
    end
    // reduce until one more subtraction would go negative
    while (c >= 128'(m)) begin
        c = c - 128'(m);
    end
    return c[64:0];
endfunction

// wraps naturally at 2^65
function automatic logic [64:0] add_sub_ref(input logic [64:0] x,
                                            input logic [64:0] y,
                                            input logic        sub);
    logic [64:0] r;
    if (sub) begin
        r = x - y;
    end else begin
        r = x + y;
    end
    return r;
endfunction

`endif

//--- dv/tb_mont.sv
module tb_mont;

    localparam int N          = 64;
    localparam int LIMB_W     = 16;
    localparam int LIMBS      = (N + LIMB_W) / LIMB_W;
    localparam int CLK_PERIOD = 8;
    // each bit takes a scan, two adder passes with their checks and a shift
    localparam int MUL_CYC    = N * (2 * LIMBS + 3) + 2 * (LIMBS + 2) + 4;
    localparam int OP_LIMIT   = MUL_CYC + 16;
    localparam int NUM_OPS    = 45;

    logic         clk;
    logic         rst;
    logic         start;
    logic         mode_add;
    logic         add_sub;
    logic [N-1:0] in_a;
    logic [N-1:0] in_b;
    logic [N-1:0] in_m;
    logic [N:0]   add_a;
    logic [N:0]   add_b;
    logic [N:0]   result;
    logic         done;

    int seed         = 78368;
    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    `include "mont_ref.svh"

    mont_top #(
        .N      (N),
        .LIMB_W (LIMB_W)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .mode_add (mode_add),
        .add_sub  (add_sub),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_m     (in_m),
        .add_a    (add_a),
        .add_b    (add_b),
        .result   (result),
        .done     (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(NUM_OPS * OP_LIMIT * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [N-1:0] rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [N:0] rand_wide();
        return {1'($random(seed)), rand_word()};
    endfunction

    task automatic report_mismatch(input string name, input logic [N:0] exp,
                                   input logic [N:0] act);
        $display("FAILED %s expected %h actual %h", name, exp, act);
        errors++;
    endtask

    task automatic close_test(input string name, input int err_at_start);
        if (errors == err_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_at_start);
        end
    endtask

    // pulses start and waits for done with an optional stray start and hold check
    task automatic run_op(input int poke_at, input bit hold_chk,
                          input logic [N:0] hold_val, output int cycles);
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start  = 1'b0;
        cycles = 1;
        while (!done && cycles < OP_LIMIT) begin
            if (hold_chk && result !== hold_val) begin
                $display("result changed %0d cycles into the next operation", cycles);
                errors++;
            end
            @(posedge clk);
            #1;
            cycles++;
            start = (cycles == poke_at);
        end
        start = 1'b0;
        if (!done) begin
            $display("no done within %0d cycles of start", OP_LIMIT);
            errors++;
        end
    endtask

    task automatic mont_case(input string name, input logic [N-1:0] a,
                             input logic [N-1:0] b, input logic [N-1:0] m);
        logic [N:0] exp;
        int         cycles;
        mode_add = 1'b0;
        add_sub  = 1'b0;
        in_a     = a;
        in_b     = b;
        in_m     = m;
        run_op(0, 1'b0, '0, cycles);
        exp = mont_mul_ref(a, b, m);
        if (result !== exp) begin
            report_mismatch(name, exp, result);
        end
        if (result >= {1'b0, m}) begin
            $display("%s: result is not below the modulus", name);
            errors++;
        end
    endtask

    task automatic add_case(input string name, input logic sub,
                            input logic [N:0] x, input logic [N:0] y);
        logic [N:0] exp;
        int         cycles;
        mode_add = 1'b1;
        add_sub  = sub;
        add_a    = x;
        add_b    = y;
        run_op(0, 1'b0, '0, cycles);
        exp = add_sub_ref(x, y, sub);
        if (result !== exp) begin
            report_mismatch(name, exp, result);
        end
    endtask

    task automatic reset_busy_start();
        int           err0;
        int           cycles;
        logic [N-1:0] m;
        logic [N:0]   exp;
        err0 = errors;
        repeat (10) begin
            @(posedge clk);
            #1;
            if (done) begin
                $display("done went high after reset without a start");
                errors++;
            end
        end
        m        = rand_word() | 1'b1;
        in_a     = rand_word() % m;
        in_b     = rand_word() % m;
        in_m     = m;
        mode_add = 1'b0;
        // second start lands in the middle of the multiply
        run_op(20, 1'b0, '0, cycles);
        exp = mont_mul_ref(in_a, in_b, in_m);
        if (result !== exp) begin
            report_mismatch("reset_busy_start", exp, result);
        end
        close_test("reset_busy_start", err0);
    endtask

    task automatic mont_edges();
        int           err0;
        logic [N-1:0] m;
        logic [N-1:0] full;
        err0 = errors;
        m    = rand_word() | 1'b1;
        full = '1;
        mont_case("mont_a_zero", '0, rand_word() % m, m);
        mont_case("mont_a_one", 1, rand_word() % m, m);
        mont_case("mont_b_max", rand_word() % m, m - 1, m);
        mont_case("mont_m_all_ones", rand_word() % full, full - 1, full);
        close_test("mont_edges", err0);
    endtask

    task automatic mont_random();
        int           err0;
        logic [N-1:0] m;
        err0 = errors;
        repeat (20) begin
            m = rand_word() | 1'b1;
            mont_case("mont_random", rand_word() % m, rand_word() % m, m);
        end
        close_test("mont_random", err0);
    endtask

    task automatic add_sub_pairs(input logic sub);
        int    err0;
        string name;
        err0 = errors;
        name = sub ? "sub_random" : "add_random";
        repeat (5) begin
            add_case(name, sub, rand_wide(), rand_wide());
        end
        if (sub) begin
            add_case(name, sub, 65'd5, 65'd9);
            add_case(name, sub, '0, '1);
        end else begin
            // carry into bit 64 and a wrap past 2^65
            add_case(name, sub, {1'b0, {N{1'b1}}}, 65'd1);
            add_case(name, sub, '1, 65'd2);
        end
        close_test(name, err0);
    endtask

    task automatic add_latency_hold();
        int           err0;
        int           cycles;
        logic [N:0]   held;
        logic [N:0]   exp;
        logic [N-1:0] m;
        err0     = errors;
        mode_add = 1'b1;
        add_sub  = 1'b0;
        add_a    = rand_wide();
        add_b    = rand_wide();
        run_op(0, 1'b0, '0, cycles);
        if (cycles != LIMBS + 1) begin
            report_mismatch("add_latency", (N + 1)'(LIMBS + 1), (N + 1)'(cycles));
        end
        held     = result;
        m        = rand_word() | 1'b1;
        in_a     = rand_word() % m;
        in_b     = rand_word() % m;
        in_m     = m;
        mode_add = 1'b0;
        run_op(0, 1'b1, held, cycles);
        exp = mont_mul_ref(in_a, in_b, in_m);
        if (result !== exp) begin
            report_mismatch("add_latency", exp, result);
        end
        held     = result;
        mode_add = 1'b1;
        add_sub  = 1'b1;
        add_a    = rand_wide();
        add_b    = rand_wide();
        run_op(0, 1'b1, held, cycles);
        if (cycles != LIMBS + 1) begin
            report_mismatch("add_latency", (N + 1)'(LIMBS + 1), (N + 1)'(cycles));
        end
        exp = add_sub_ref(add_a, add_b, 1'b1);
        if (result !== exp) begin
            report_mismatch("add_latency", exp, result);
        end
        close_test("add_latency", err0);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        start    = 1'b0;
        mode_add = 1'b0;
        add_sub  = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_m     = '0;
        add_a    = '0;
        add_b    = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_busy_start();
        mont_edges();
        mont_random();
        add_sub_pairs(1'b0);
        add_sub_pairs(1'b1);
        add_latency_hold();
        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+dv
common/mont_pkg.sv
common/mont_ctrl_pkg.sv
rtl/mp_adder.sv
mont_core/mont_ctrl.sv
mont_core/mont_datapath.sv
rtl/mont_top.sv
dv/tb_mont.sv

//--- Bender.yml
package:
  name: mont_mul

sources:
  - files:
      - common/mont_pkg.sv
      - common/mont_ctrl_pkg.sv
      - rtl/mp_adder.sv
      - mont_core/mont_ctrl.sv
      - mont_core/mont_datapath.sv
      - rtl/mont_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mont.sv
